/* include/axi_conv_params.svh */
// fixed widths for 24-bit master beats over 32-bit slave beats, bursts capped at 64 master beats
`ifndef AXI_CONV_PARAMS_SVH
`define AXI_CONV_PARAMS_SVH

// byte address width, same on both sides
`define AXI_ADDR_W      32

// master side beat width in bits
`define AXI_MDATA_W     24

// slave side beat width in bits
`define AXI_SDATA_W     32

// arlen field width
`define AXI_LEN_W       8

// largest master burst in beats
// must stay a multiple of four
`define AXI_MAX_MBEATS  64

`endif

/* rtl/axi_conv_types_pkg.sv */
// scalar types of the read downsizer, widths come from the shared params header
`include "axi_conv_params.svh"

package axi_conv_types_pkg;

    // byte address, passed through unchanged
    typedef logic [`AXI_ADDR_W-1:0]  addr_t;

    // beats minus one
    typedef logic [`AXI_LEN_W-1:0]   len_t;

    // one master beat, three bytes
    typedef logic [`AXI_MDATA_W-1:0] mdata_t;

    // one slave beat, four bytes
    typedef logic [`AXI_SDATA_W-1:0] sdata_t;

    // okay, exokay, slverr, decerr
    typedef logic [1:0]              resp_t;

    // bytes held in the repack buffer, 0 to 6
    typedef logic [2:0]              fill_t;

    // address side burst sequencing
    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT_DATA
    } rd_state_t;

endpackage

/* rtl/axi_conv_chan_pkg.sv */
// channel payloads only, valid and ready travel as separate single-bit signals
package axi_conv_chan_pkg;

    import axi_conv_types_pkg::*;

    // read address payload
    // same layout on master and slave side
    typedef struct packed {
        addr_t addr;
        len_t  len;
        logic  id;
    } ar_chan_t;

    // read data toward the master, 24-bit beats
    typedef struct packed {
        mdata_t data;
        resp_t  resp;
        logic   last;
        logic   id;
    } m_r_chan_t;

    // read data from the slave, 32-bit beats
    typedef struct packed {
        sdata_t data;
        resp_t  resp;
        logic   last;
        logic   id;
    } s_r_chan_t;

endpackage

/* rtl/ar_len_convert.sv */
// one read in flight at a time, master bursts must be 4 to 64 beats in steps of four
`timescale 1ns/1ps
`include "axi_conv_params.svh"

module ar_len_convert (
    input  logic                        axi_inf_slaver,
    input  logic                        rst,
    input  axi_conv_chan_pkg::ar_chan_t m_ar,
    input  logic                        m_arvalid,
    output logic                        m_arready,
    output axi_conv_chan_pkg::ar_chan_t s_ar,
    output logic                        s_arvalid,
    input  logic                        s_arready,
    input  logic                        burst_done
);
    import axi_conv_types_pkg::*;
    import axi_conv_chan_pkg::*;

    // holds the largest master beat count
    localparam int BEAT_W = $clog2(`AXI_MAX_MBEATS) + 1;

    rd_state_t         state_q;
    rd_state_t         state_d;
    ar_chan_t          req_q;
    logic [BEAT_W-1:0] m_beats;
    logic [BEAT_W-1:0] s_beats;
    len_t              s_len;

    // master beat count from arlen
    assign m_beats = BEAT_W'(m_ar.len) + BEAT_W'(1);

    // 4 master beats of 3 bytes fill 3 slave words
    assign s_beats = m_beats - (m_beats >> 2);
    assign s_len   = len_t'(s_beats) - len_t'(1);

    // accept only while nothing is outstanding
    assign m_arready = (state_q == IDLE);
    assign s_arvalid = (state_q == ISSUE);
    assign s_ar      = req_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (m_arvalid) begin
                    state_d = ISSUE;
                end
            end
            ISSUE: begin
                // held until the slave takes it
                if (s_arready) begin
                    state_d = WAIT_DATA;
                end
            end
            WAIT_DATA: begin
                // last repacked beat has left
                if (burst_done) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge axi_inf_slaver) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request captured with the rescaled length
    always_ff @(posedge axi_inf_slaver) begin
        if (m_arvalid && m_arready) begin
            req_q.addr <= m_ar.addr;
            req_q.len  <= s_len;
            req_q.id   <= m_ar.id;
        end
    end

endmodule

/* rtl/r_width_downsize.sv */
// little-endian byte repack, bursts must end on a whole 24-bit beat and only one may be in flight
`timescale 1ns/1ps
`include "axi_conv_params.svh"

module r_width_downsize (
    input  logic                         axi_inf_slaver,
    input  logic                         rst,
    input  axi_conv_chan_pkg::s_r_chan_t s_r,
    input  logic                         s_rvalid,
    output logic                         s_rready,
    output axi_conv_chan_pkg::m_r_chan_t m_r,
    output logic                         m_rvalid,
    input  logic                         m_rready,
    output logic                         burst_done
);
    import axi_conv_types_pkg::*;
    import axi_conv_chan_pkg::*;

    localparam int M_BYTES   = `AXI_MDATA_W / 8;
    localparam int S_BYTES   = `AXI_SDATA_W / 8;
    // partial master beat plus one full slave beat
    localparam int BUF_BYTES = M_BYTES - 1 + S_BYTES;

    // byte 0 is the oldest stream byte
    logic [BUF_BYTES-1:0][7:0] byte_q;
    logic [BUF_BYTES-1:0][7:0] byte_d;
    // response of the slave beat each byte came from
    resp_t [BUF_BYTES-1:0]     resp_q;
    resp_t [BUF_BYTES-1:0]     resp_d;
    fill_t                     fill_q;
    fill_t                     fill_d;
    fill_t                     cnt_pop;
    logic                      seen_last_q;
    logic                      id_q;
    logic                      pop;
    logic                      push;

    // higher code is more severe, decerr over slverr over okay
    function automatic resp_t worst_resp(input resp_t a, input resp_t b);
        return (a > b) ? a : b;
    endfunction

    assign pop  = m_rvalid && m_rready;
    assign push = s_rvalid && s_rready;

    // room for four more bytes, counting a pop in this cycle
    assign s_rready = (fill_q <= fill_t'(M_BYTES - 1)) ||
                      (pop && (fill_q != fill_t'(BUF_BYTES)));

    // a full master beat is ready whenever three bytes sit in front
    assign m_rvalid = (fill_q >= fill_t'(M_BYTES));

    assign m_r.data = byte_q[M_BYTES-1:0];
    assign m_r.resp = worst_resp(worst_resp(resp_q[0], resp_q[1]), resp_q[2]);
    // slave is done and this beat drains the buffer
    assign m_r.last = seen_last_q && (fill_q == fill_t'(M_BYTES));
    assign m_r.id   = id_q;

    assign burst_done = pop && m_r.last;

    // bytes left after this cycle's pop
    assign cnt_pop = pop ? (fill_q - fill_t'(M_BYTES)) : fill_q;

    always_comb begin
        int k;
        // drop the three oldest bytes on a pop
        byte_d = pop ? (byte_q >> (8 * M_BYTES)) : byte_q;
        resp_d = pop ? (resp_q >> (2 * M_BYTES)) : resp_q;
        // new word lands right behind what remains
        for (int i = 0; i < BUF_BYTES; i++) begin
            k = i - int'(cnt_pop);
            if (push && (k >= 0) && (k < S_BYTES)) begin
                byte_d[i] = s_r.data[8*k +: 8];
                resp_d[i] = s_r.resp;
            end
        end
        fill_d = cnt_pop + (push ? fill_t'(S_BYTES) : fill_t'(0));
    end

    always_ff @(posedge axi_inf_slaver) begin
        if (rst) begin
            fill_q      <= '0;
            seen_last_q <= 1'b0;
        end else begin
            fill_q <= fill_d;
            // cleared as the final master beat leaves
            if (burst_done) begin
                seen_last_q <= 1'b0;
            end else if (push && s_r.last) begin
                seen_last_q <= 1'b1;
            end
        end
    end

    // payload only
    always_ff @(posedge axi_inf_slaver) begin
        byte_q <= byte_d;
        resp_q <= resp_d;
        // id is constant over a burst
        if (push) begin
            id_q <= s_r.id;
        end
    end

endmodule

/* rtl/axi_read_downsizer.sv */
// read path only, single outstanding burst, word aligned addresses and master bursts of 4n beats
`timescale 1ns/1ps

module axi_read_downsizer (
    input  logic                         axi_inf_slaver,
    input  logic                         rst,
    // master side, 24-bit beats
    input  axi_conv_chan_pkg::ar_chan_t  m_ar,
    input  logic                         m_arvalid,
    output logic                         m_arready,
    output axi_conv_chan_pkg::m_r_chan_t m_r,
    output logic                         m_rvalid,
    input  logic                         m_rready,
    // slave side, 32-bit beats
    output axi_conv_chan_pkg::ar_chan_t  s_ar,
    output logic                         s_arvalid,
    input  logic                         s_arready,
    input  axi_conv_chan_pkg::s_r_chan_t s_r,
    input  logic                         s_rvalid,
    output logic                         s_rready
);

    // last master beat out, frees the address side
    logic burst_done;

    // address rescale and burst sequencing
    ar_len_convert ar_len_convert_inst (
        .axi_inf_slaver (axi_inf_slaver),
        .rst            (rst),
        .m_ar           (m_ar),
        .m_arvalid      (m_arvalid),
        .m_arready      (m_arready),
        .s_ar           (s_ar),
        .s_arvalid      (s_arvalid),
        .s_arready      (s_arready),
        .burst_done     (burst_done)
    );

    // 32 to 24 bit data repack
    r_width_downsize r_width_downsize_inst (
        .axi_inf_slaver (axi_inf_slaver),
        .rst            (rst),
        .s_r            (s_r),
        .s_rvalid       (s_rvalid),
        .s_rready       (s_rready),
        .m_r            (m_r),
        .m_rvalid       (m_rvalid),
        .m_rready       (m_rready),
        .burst_done     (burst_done)
    );

endmodule

/* bench/clock_gen.sv */
// free-running 8 ns clock, reset high for the first 8 cycles then released on a falling edge
`timescale 1ns/1ps

module clock_gen (
    output logic axi_inf_slaver,
    output logic rst
);

    // 125 MHz
    initial begin
        axi_inf_slaver = 1'b0;
        forever #4 axi_inf_slaver = ~axi_inf_slaver;
    end

    // release away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge axi_inf_slaver);
        @(negedge axi_inf_slaver);
        rst = 1'b0;
    end

endmodule

/* bench/axi_read_downsizer_props.sv */
// hold checks apply only outside reset, the reset check looks one cycle past each reset cycle
`timescale 1ns/1ps

module axi_read_downsizer_props (
    input logic                         axi_inf_slaver,
    input logic                         rst,
    input axi_conv_chan_pkg::ar_chan_t  s_ar,
    input logic                         s_arvalid,
    input logic                         s_arready,
    input axi_conv_chan_pkg::m_r_chan_t m_r,
    input logic                         m_rvalid,
    input logic                         m_rready
);

    // failed property count
    int fail_cnt = 0;

    // slave request held until taken
    ar_hold: assert property (@(posedge axi_inf_slaver) disable iff (rst)
        (s_arvalid && !s_arready) |=> (s_arvalid && $stable(s_ar)))
        else begin
            fail_cnt++;
            $error("s_ar dropped or changed before s_arready");
        end

    // repacked beat held under back-pressure
    r_hold: assert property (@(posedge axi_inf_slaver) disable iff (rst)
        (m_rvalid && !m_rready) |=> (m_rvalid && $stable(m_r)))
        else begin
            fail_cnt++;
            $error("m_r dropped or changed before m_rready");
        end

    // both valids clear right after reset
    rst_quiet: assert property (@(posedge axi_inf_slaver)
        rst |=> (!s_arvalid && !m_rvalid))
        else begin
            fail_cnt++;
            $error("valid high in the cycle after reset");
        end

endmodule

bind axi_read_downsizer axi_read_downsizer_props axi_read_downsizer_props_inst (.*);

/* bench/axi_read_downsizer_tb.sv */
// random bursts against a byte-stream model with inputs driven on the falling edge and sampled 1 ns later
`timescale 1ns/1ps

module axi_read_downsizer_tb;
    import axi_conv_types_pkg::*;
    import axi_conv_chan_pkg::*;

    localparam int NUM_BURSTS = 40;
    // bursts times largest burst times slack per beat
    localparam int LIMIT = NUM_BURSTS * 64 * 8;

    logic axi_inf_slaver, rst;
    ar_chan_t  m_ar, s_ar;
    m_r_chan_t m_r;
    s_r_chan_t s_r;
    logic m_arvalid, m_arready, m_rvalid, m_rready;
    logic s_arvalid, s_arready, s_rvalid, s_rready;

    // pending master requests
    addr_t req_addr_q[$];
    len_t  req_len_q[$];
    logic  req_id_q[$];
    // master beats of the open burst
    int    burst_q[$];
    // model byte stream and per-byte response
    logic [7:0] bytes_q[$];
    resp_t      resp_q[$];
    int errs, prop_errs, cycles, sent, done, beat_cnt, s_left;
    logic busy, cur_id, s_id, m_ar_x, s_r_x;

    clock_gen clock_gen_inst (.axi_inf_slaver(axi_inf_slaver), .rst(rst));

    axi_read_downsizer axi_read_downsizer_inst (.*);

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        errs++;
        $display("** Error at %0t: %s got %0h expected %0h", $time, what, got, exp);
    endtask

    // new inputs for the coming rising edge
    task automatic drive_inputs();
        if (m_ar_x) m_arvalid = 1'b0;
        if (s_r_x) s_rvalid = 1'b0;
        m_rready  = ($urandom % 4) != 0;
        s_arready = ($urandom % 2) != 0;
        if (!m_arvalid && sent < NUM_BURSTS && ($urandom % 4) == 0) begin
            m_ar.addr = $urandom & 32'hffff_fffc;
            // 4 to 64 beats in steps of four
            m_ar.len  = len_t'(((($urandom % 16) + 1) * 4) - 1);
            m_ar.id   = ($urandom % 2) != 0;
            m_arvalid = 1'b1;
        end
        // slave beats with random gaps and some slverr
        if (!s_rvalid && s_left > 0 && ($urandom % 3) != 0) begin
            s_r.data  = $urandom;
            s_r.resp  = (($urandom % 8) == 0) ? 2'b10 : 2'b00;
            s_r.last  = (s_left == 1);
            s_r.id    = s_id;
            s_rvalid  = 1'b1;
        end
    endtask

    // transfers that the next rising edge will complete
    task automatic sample_outputs();
        logic [7:0] b0, b1, b2;
        resp_t w;
        int exp_len;
        m_ar_x = m_arvalid && m_arready;
        s_r_x  = s_rvalid && s_rready;
        assert (!(s_arvalid && busy)) else begin
            errs++;
            $display("second s_arvalid seen at %0t before the last master beat", $time);
        end
        if (m_ar_x) begin
            req_addr_q.push_back(m_ar.addr);
            req_len_q.push_back(m_ar.len);
            req_id_q.push_back(m_ar.id);
            sent++;
        end
        if (s_arvalid && s_arready) begin
            // 4 master beats fill 3 slave beats
            exp_len = ((int'(req_len_q[0]) + 1) * 3) / 4 - 1;
            assert (s_ar.addr == req_addr_q[0])
                else report_mismatch("s_ar addr", s_ar.addr, req_addr_q[0]);
            assert (s_ar.id == req_id_q[0])
                else report_mismatch("s_ar id", 32'(s_ar.id), 32'(req_id_q[0]));
            assert (int'(s_ar.len) == exp_len)
                else report_mismatch("s_ar len", 32'(s_ar.len), 32'(exp_len));
            burst_q.push_back(int'(req_len_q[0]) + 1);
            cur_id = req_id_q[0];
            void'(req_addr_q.pop_front());
            void'(req_len_q.pop_front());
            void'(req_id_q.pop_front());
            s_left = int'(s_ar.len) + 1;
            s_id   = s_ar.id;
            busy   = 1'b1;
        end
        // master beat leaves before new bytes arrive
        if (m_rvalid && m_rready) begin
            assert (bytes_q.size() >= 3 && burst_q.size() > 0) else begin
                errs++;
                $display("master beat at %0t with no data owed", $time);
            end
            if (bytes_q.size() >= 3 && burst_q.size() > 0) begin
                b0 = bytes_q.pop_front();
                b1 = bytes_q.pop_front();
                b2 = bytes_q.pop_front();
                w = resp_q.pop_front();
                // most severe of the three bytes
                for (int i = 0; i < 2; i++) begin
                    if (resp_q[0] > w) w = resp_q[0];
                    void'(resp_q.pop_front());
                end
                beat_cnt++;
                assert (m_r.data == {b2, b1, b0})
                    else report_mismatch("m_r data", 32'(m_r.data), 32'({b2, b1, b0}));
                assert (m_r.resp == w)
                    else report_mismatch("m_r resp", 32'(m_r.resp), 32'(w));
                assert (m_r.id == cur_id)
                    else report_mismatch("m_r id", 32'(m_r.id), 32'(cur_id));
                assert (m_r.last == (beat_cnt == burst_q[0]))
                    else report_mismatch("m_r last", 32'(m_r.last),
                                         32'(beat_cnt == burst_q[0]));
                if (beat_cnt == burst_q[0]) begin
                    void'(burst_q.pop_front());
                    beat_cnt = 0;
                    busy = 1'b0;
                    done++;
                end
            end
        end
        if (s_r_x) begin
            for (int i = 0; i < 4; i++) begin
                bytes_q.push_back(s_r.data[8*i +: 8]);
                resp_q.push_back(s_r.resp);
            end
            s_left--;
        end
    endtask

    initial begin
        void'($urandom(32'he8891e5d));
        m_ar = '0;
        s_r = '0;
        m_arvalid = 1'b0;
        m_rready = 1'b0;
        s_arready = 1'b0;
        s_rvalid = 1'b0;
        errs = 0;
        prop_errs = 0;
        cycles = 0;
        sent = 0;
        done = 0;
        beat_cnt = 0;
        s_left = 0;
        busy = 1'b0;
        cur_id = 1'b0;
        s_id = 1'b0;
        m_ar_x = 1'b0;
        s_r_x = 1'b0;
        @(negedge rst);
        while (done < NUM_BURSTS && cycles < LIMIT) begin
            @(negedge axi_inf_slaver);
            cycles++;
            drive_inputs();
            #1;
            sample_outputs();
        end
        if (done < NUM_BURSTS) begin
            errs++;
            $display("timeout: run hung after %0d cycles, %0d of %0d bursts done",
                     cycles, done, NUM_BURSTS);
        end
        assert (bytes_q.size() == 0) else begin
            errs++;
            $display("%0d stream bytes never reached the master", bytes_q.size());
        end
        prop_errs = axi_read_downsizer_inst.axi_read_downsizer_props_inst.fail_cnt;
        $display("errors: %0d checks, %0d properties", errs, prop_errs);
        if (errs == 0 && prop_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+include
rtl/axi_conv_types_pkg.sv
rtl/axi_conv_chan_pkg.sv
rtl/ar_len_convert.sv
rtl/r_width_downsize.sv
rtl/axi_read_downsizer.sv
bench/clock_gen.sv
bench/axi_read_downsizer_props.sv
bench/axi_read_downsizer_tb.sv

/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module axi_read_downsizer_tb

sim:
	verilator --binary --timing --assert -f sim.f --top-module axi_read_downsizer_tb -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "test passed" sim.log
	! grep -q "test failed" sim.log

clean:
	rm -rf obj_dir sim.log
